/* logic/sfu_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing macros for the sfu: lanes, widths, queue depth, fraction bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SFU_CONSTS_SVH
`define SFU_CONSTS_SVH

// psum columns handled per beat
`define SFU_COLS 8

// width of one column partial sum
`define SFU_PSUM_BW 12

// local lane sum, 4 bits headroom covers eight lanes
`define SFU_SUM_BW (`SFU_PSUM_BW + 4)

// entries per queue
`define SFU_FIFO_DEPTH 16

// lane is scaled by 2^frac before the divide
`define SFU_FRAC_BITS 12

`endif

/* logic/sfu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sfu types: lane vector, lane sum, local queue entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "sfu_consts.svh"

package sfu_pkg;

  // eight 12-bit lanes, lane 0 in the low bits
  // same layout for raw input, magnitudes and normalized output
  typedef logic [`SFU_COLS-1:0][`SFU_PSUM_BW-1:0] psum_vec_t;

  // unsigned sum of lane magnitudes
  // also the format exchanged with the peer core
  typedef logic [`SFU_SUM_BW-1:0] psum_sum_t;

  // local queue payload
  // magnitudes and their sum are written and popped together
  typedef struct packed {
    psum_vec_t abs_vec;
    psum_sum_t local_sum;
  } norm_entry_t;

endpackage

/* logic/psum_abs_sum.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accumulate stage: lane magnitudes, lane sum and queue write strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sfu_consts.svh"

module psum_abs_sum import sfu_pkg::*; (
  input  psum_vec_t   psum_in,
  input  logic        sign_mode,
  input  logic        acc,
  input  logic        ofifo_valid,
  output norm_entry_t entry,
  output psum_sum_t   entry_sum,
  output logic        wr
);

  psum_vec_t abs_vec;
  psum_sum_t lane_sum;

  // per-lane sign handling
  for (genvar i = 0; i < `SFU_COLS; i++) begin : g_abs
    logic neg;

    // top bit only means negative in signed mode
    assign neg = sign_mode & psum_in[i][`SFU_PSUM_BW-1];

    // two's complement magnitude
    // -2048 maps to 2048, still fits unsigned in 12 bits
    assign abs_vec[i] = neg ? (~psum_in[i] + 1'b1) : psum_in[i];
  end

  // sum of the eight magnitudes
  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < `SFU_COLS; i++) begin
      // zero extend each lane to the sum width
      lane_sum = lane_sum + psum_sum_t'(abs_vec[i]);
    end
  end

  // local queue payload
  assign entry.abs_vec   = abs_vec;
  assign entry.local_sum = lane_sum;

  // same sum goes out to the peer core
  assign entry_sum = lane_sum;

  // accumulate beat
  // one strobe writes the local and the outgoing queue
  assign wr = acc & ofifo_valid;

endmodule

/* logic/sfu_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single clock queue, generic payload, head shown while not empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sfu_consts.svh"

module sfu_fifo import sfu_pkg::*; #(
  parameter type payload_t = psum_sum_t,
  parameter int  DEPTH     = `SFU_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr,
  input  payload_t din,
  input  logic     rd,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  localparam int PTR_BW = $clog2(DEPTH);
  localparam int CNT_BW = PTR_BW + 1;

  payload_t          mem [DEPTH];
  logic [PTR_BW-1:0] wr_ptr;
  logic [PTR_BW-1:0] rd_ptr;
  logic [CNT_BW-1:0] count;

  // wrap at DEPTH, also correct for non power of two depths
  function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
    if (ptr == PTR_BW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // storage
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous write and read keeps the count
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first-word fall-through
  // entry written at edge N is at the head right after N
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_BW'(DEPTH));

  // upstream must respect the depth
  a_no_write_full : assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
    else $error("sfu_fifo: write while full");

  // consumer must see data before popping
  a_no_read_empty : assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
    else $error("sfu_fifo: read while empty");

endmodule

/* logic/norm_divider.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide phase: pop decision, per-lane divide by two-core sum, output reg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sfu_consts.svh"

module norm_divider import sfu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        div,
  input  norm_entry_t local_head,
  input  logic        local_empty,
  input  psum_sum_t   peer_sum,
  input  logic        peer_empty,
  output logic        pop,
  output psum_vec_t   sfp_out,
  output logic        sfp_out_valid
);

  // local plus peer sum needs one extra bit
  localparam int TOT_BW = `SFU_SUM_BW + 1;
  // lane shifted left by the fraction bits
  localparam int NUM_BW = `SFU_PSUM_BW + `SFU_FRAC_BITS;

  logic [TOT_BW-1:0] tot_sum;
  logic              tot_zero;
  psum_vec_t         quot;

  // pop only when both sources hold data
  // same strobe pops the local queue and the peer
  assign pop = div & ~local_empty & ~peer_empty;

  // combined two-core sum
  assign tot_sum  = TOT_BW'(local_head.local_sum) + TOT_BW'(peer_sum);
  assign tot_zero = (tot_sum == '0);

  // one divider per lane
  for (genvar i = 0; i < `SFU_COLS; i++) begin : g_lane
    logic [NUM_BW-1:0] num;
    logic [NUM_BW-1:0] q;

    // lane times 2^frac
    assign num = {local_head.abs_vec[i], {`SFU_FRAC_BITS{1'b0}}};

    // zero combined sum gives a zero lane
    assign q = tot_zero ? '0 : num / NUM_BW'(tot_sum);

    // keep the low 12 bits
    assign quot[i] = q[`SFU_PSUM_BW-1:0];
  end

  // quotient register, loaded on pop
  always_ff @(posedge clk) begin
    if (pop) begin
      sfp_out <= quot;
    end
  end

  // valid for exactly the cycle after a pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sfp_out_valid <= 1'b0;
    end else begin
      sfp_out_valid <= pop;
    end
  end

  // peer queue head only moves when this side pops it
  a_peer_head_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (!peer_empty && !pop) |=> $stable(peer_sum))
    else $error("norm_divider: peer sum changed without a pop");

  // accumulate stage invariant seen at the queue head
  // zero local sum only comes with an all-zero magnitude vector
  a_zero_sum_lanes : assert property (@(posedge clk) disable iff (!rst_n)
    (!local_empty && local_head.local_sum == '0) |-> (local_head.abs_vec == '0))
    else $error("norm_divider: zero sum with non-zero lanes");

endmodule

/* logic/sfu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sfu top: accumulate stage, local and outgoing queues, divider
// two-core normalization of eight column partial sums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sfu_consts.svh"

module sfu_top import sfu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // psum columns from the array
  input  psum_vec_t psum_in,
  input  logic      sign_mode,
  input  logic      acc,
  input  logic      ofifo_valid,
  input  logic      div,

  // normalized result
  output psum_vec_t sfp_out,
  output logic      sfp_out_valid,

  // peer sum coming in, popped from here
  input  psum_sum_t oc_sfu_sum,
  input  logic      oc_sfu_fifo_empty,
  output logic      oc_sfu_fifo_rd,

  // this core's sum going out, popped by the peer
  input  logic      tc_sfu_fifo_rd,
  output psum_sum_t tc_sfu_sum,
  output logic      tc_sfu_fifo_empty
);

  // accumulate stage outputs
  norm_entry_t entry;
  psum_sum_t   entry_sum;
  logic        wr;

  // local queue head side
  norm_entry_t local_head;
  logic        local_empty;

  // divide strobe
  logic        pop;

  // peer pops on the same strobe as the local queue
  assign oc_sfu_fifo_rd = pop;

  // magnitudes and lane sum, combinational
  psum_abs_sum u_psum_abs_sum (
    .psum_in     (psum_in),
    .sign_mode   (sign_mode),
    .acc         (acc),
    .ofifo_valid (ofifo_valid),
    .entry       (entry),
    .entry_sum   (entry_sum),
    .wr          (wr)
  );

  // vector plus local sum, waits for the divide phase
  // overflow is checked inside the queue
  sfu_fifo #(
    .payload_t (norm_entry_t),
    .DEPTH     (`SFU_FIFO_DEPTH)
  ) local_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .din   (entry),
    .rd    (pop),
    .head  (local_head),
    .empty (local_empty),
    .full  ()
  );

  // local sum for the peer core
  // written with the local queue, drained only by the peer
  sfu_fifo #(
    .payload_t (psum_sum_t),
    .DEPTH     (`SFU_FIFO_DEPTH)
  ) out_sum_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .din   (entry_sum),
    .rd    (tc_sfu_fifo_rd),
    .head  (tc_sfu_sum),
    .empty (tc_sfu_fifo_empty),
    .full  ()
  );

  // pop decision and registered quotients
  norm_divider u_norm_divider (
    .clk           (clk),
    .rst_n         (rst_n),
    .div           (div),
    .local_head    (local_head),
    .local_empty   (local_empty),
    .peer_sum      (oc_sfu_sum),
    .peer_empty    (oc_sfu_fifo_empty),
    .pop           (pop),
    .sfp_out       (sfp_out),
    .sfp_out_valid (sfp_out_valid)
  );

endmodule

/* verification/sfu_tb_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sfu directed tests, compare task, peer helpers, reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SFU_TB_TASKS_SVH
`define SFU_TB_TASKS_SVH

task automatic abort_run();
  $display("CHECKS FAILED");
  $fatal(1, "run stopped at the first failure");
endtask

task automatic check(input string name, input logic [127:0] expected,
                     input logic [127:0] actual);
  if (actual !== expected) begin
    $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    abort_run();
  end
endtask

// all tasks start and end 1 ns after a rising edge
task automatic tick();
  @(posedge clk);
  #1;
endtask

// reference model
// magnitude of a lane, two's complement only in signed mode
function automatic logic [`SFU_PSUM_BW-1:0] lane_mag(input logic [`SFU_PSUM_BW-1:0] lane,
                                                     input logic signed_mode);
  int v;
  v = int'(lane);
  if (signed_mode && lane[`SFU_PSUM_BW-1]) begin
    v = 4096 - v;
  end
  return 12'(v);
endfunction

function automatic psum_sum_t lane_total(input psum_vec_t vec, input logic signed_mode);
  int s;
  s = 0;
  for (int i = 0; i < `SFU_COLS; i++) begin
    s = s + int'(lane_mag(vec[i], signed_mode));
  end
  return psum_sum_t'(s);
endfunction

// lane times 4096 over the two-core sum, low 12 bits
function automatic logic [`SFU_PSUM_BW-1:0] norm_lane(input logic [`SFU_PSUM_BW-1:0] mag,
                                                      input int total);
  int num;
  if (total == 0) begin
    return '0;
  end
  num = int'(mag) * 4096;
  return 12'(num / total);
endfunction

function automatic psum_vec_t expected_out(input psum_vec_t vec, input logic signed_mode,
                                           input psum_sum_t peer);
  psum_vec_t res;
  int        total;
  total = int'(lane_total(vec, signed_mode)) + int'(peer);
  for (int i = 0; i < `SFU_COLS; i++) begin
    res[i] = norm_lane(lane_mag(vec[i], signed_mode), total);
  end
  return res;
endfunction

// peer outputs follow the head of its queue
task automatic drive_peer();
  oc_sfu_fifo_empty = (peer_q.size() == 0);
  oc_sfu_sum        = (peer_q.size() == 0) ? '0 : peer_q[0];
endtask

task automatic push_peer(input psum_sum_t sum);
  peer_q.push_back(sum);
  drive_peer();
endtask

// one accumulate beat
task automatic accumulate(input psum_vec_t vec, input logic signed_mode);
  psum_in     = vec;
  sign_mode   = signed_mode;
  acc         = 1'b1;
  ofifo_valid = 1'b1;
  tick();
  acc         = 1'b0;
  ofifo_valid = 1'b0;
endtask

// peer side reads one sum from the outgoing queue
task automatic drain_out_sum(input psum_sum_t expected);
  tc_sfu_fifo_rd = 1'b1;
  @(negedge clk);
  check("tc_sfu_fifo_empty", 128'(1'b0), 128'(tc_sfu_fifo_empty));
  check("tc_sfu_sum", 128'(expected), 128'(tc_sfu_sum));
  tick();
  tc_sfu_fifo_rd = 1'b0;
endtask

// ends on the falling edge of the first valid cycle
task automatic wait_output(input int max_cycles);
  int n;
  n = 0;
  @(negedge clk);
  while (!sfp_out_valid) begin
    n++;
    if (n > max_cycles) begin
      $display("sfp_out_valid did not rise within %0d cycles of the divide", max_cycles);
      abort_run();
    end else begin
      @(negedge clk);
    end
  end
endtask

// one div beat, result due in the very next cycle
task automatic divide_once(input psum_vec_t expected);
  div = 1'b1;
  @(negedge clk);
  check("oc_sfu_fifo_rd", 128'(1'b1), 128'(oc_sfu_fifo_rd));
  tick();
  div = 1'b0;
  @(negedge clk);
  check("sfp_out_valid", 128'(1'b1), 128'(sfp_out_valid));
  check("sfp_out", 128'(expected), 128'(sfp_out));
  tick();
  @(negedge clk);
  check("sfp_out_valid", 128'(1'b0), 128'(sfp_out_valid));
  tick();
endtask

task automatic after_reset_idle();
  @(negedge clk);
  check("sfp_out_valid", 128'(1'b0), 128'(sfp_out_valid));
  check("oc_sfu_fifo_rd", 128'(1'b0), 128'(oc_sfu_fifo_rd));
  check("tc_sfu_fifo_empty", 128'(1'b1), 128'(tc_sfu_fifo_empty));
  tick();
endtask

task automatic unsigned_vector();
  psum_vec_t v;
  for (int i = 0; i < `SFU_COLS; i++) begin
    v[i] = 12'(100 * (i + 1));
  end
  // acc without ofifo_valid writes nothing
  psum_in     = v;
  acc         = 1'b1;
  ofifo_valid = 1'b0;
  tick();
  acc = 1'b0;
  @(negedge clk);
  check("tc_sfu_fifo_empty", 128'(1'b1), 128'(tc_sfu_fifo_empty));
  tick();
  accumulate(v, 1'b0);
  drain_out_sum(lane_total(v, 1'b0));
  push_peer(16'd400);
  divide_once(expected_out(v, 1'b0, 16'd400));
endtask

task automatic signed_vector();
  psum_vec_t v;
  // -1, -2048, 2047, -100, 5, 0, -7, 300
  v = {12'd300, 12'hff9, 12'd0, 12'd5, 12'hf9c, 12'h7ff, 12'h800, 12'hfff};
  accumulate(v, 1'b1);
  drain_out_sum(lane_total(v, 1'b1));
  push_peer(16'd1000);
  divide_once(expected_out(v, 1'b1, 16'd1000));
endtask

task automatic queue_order();
  psum_vec_t vecs[6];
  logic      modes[6];
  psum_sum_t peers[6];
  for (int i = 0; i < 6; i++) begin
    for (int l = 0; l < `SFU_COLS; l++) begin
      vecs[i][l] = 12'($urandom_range(0, 4095));
    end
    modes[i] = 1'($urandom_range(0, 1));
    accumulate(vecs[i], modes[i]);
  end
  for (int i = 0; i < 6; i++) begin
    peers[i] = psum_sum_t'($urandom_range(1, 20000));
    push_peer(peers[i]);
  end
  div = 1'b1;
  wait_output(4);
  // six back-to-back results in write order
  for (int i = 0; i < 6; i++) begin
    check("sfp_out_valid", 128'(1'b1), 128'(sfp_out_valid));
    check("sfp_out", 128'(expected_out(vecs[i], modes[i], peers[i])), 128'(sfp_out));
    @(negedge clk);
  end
  check("sfp_out_valid", 128'(1'b0), 128'(sfp_out_valid));
  tick();
  div = 1'b0;
  check("peer queue size", 128'(0), 128'(peer_q.size()));
  for (int i = 0; i < 6; i++) begin
    drain_out_sum(lane_total(vecs[i], modes[i]));
  end
  @(negedge clk);
  check("tc_sfu_fifo_empty", 128'(1'b1), 128'(tc_sfu_fifo_empty));
  tick();
endtask

task automatic back_pressure();
  psum_vec_t v;
  v = {12'd7, 12'd70, 12'd700, 12'd1, 12'd2, 12'd3, 12'd4000, 12'd9};
  accumulate(v, 1'b0);
  drain_out_sum(lane_total(v, 1'b0));
  // div waits on an empty peer
  div = 1'b1;
  repeat (5) begin
    @(negedge clk);
    check("sfp_out_valid", 128'(1'b0), 128'(sfp_out_valid));
    check("oc_sfu_fifo_rd", 128'(1'b0), 128'(oc_sfu_fifo_rd));
    tick();
  end
  push_peer(16'd12345);
  wait_output(4);
  check("sfp_out", 128'(expected_out(v, 1'b0, 16'd12345)), 128'(sfp_out));
  // exactly one result
  @(negedge clk);
  check("sfp_out_valid", 128'(1'b0), 128'(sfp_out_valid));
  tick();
  div = 1'b0;
endtask

task automatic zero_sum();
  accumulate('0, 1'b0);
  drain_out_sum(16'd0);
  push_peer(16'd0);
  div = 1'b1;
  wait_output(4);
  check("sfp_out", 128'(0), 128'(sfp_out));
  tick();
  div = 1'b0;
endtask

`endif

/* verification/sfu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sfu testbench: clock, reset, DUT, peer core model, timeout, test order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sfu_consts.svh"

module sfu_tb import sfu_pkg::*; ();

  // about ten times the length of the directed tests
  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk = 1'b0;
  logic      rst_n;

  // array side
  psum_vec_t psum_in;
  logic      sign_mode;
  logic      acc;
  logic      ofifo_valid;
  logic      div;

  // normalized result
  psum_vec_t sfp_out;
  logic      sfp_out_valid;

  // peer core interface
  psum_sum_t oc_sfu_sum;
  logic      oc_sfu_fifo_empty;
  logic      oc_sfu_fifo_rd;
  logic      tc_sfu_fifo_rd;
  psum_sum_t tc_sfu_sum;
  logic      tc_sfu_fifo_empty;

  // sums the peer core offers, head first
  psum_sum_t peer_q[$];
  int        cycle_count = 0;

  // 4 ns period
  always #2 clk = ~clk;

  sfu_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .psum_in           (psum_in),
    .sign_mode         (sign_mode),
    .acc               (acc),
    .ofifo_valid       (ofifo_valid),
    .div               (div),
    .sfp_out           (sfp_out),
    .sfp_out_valid     (sfp_out_valid),
    .oc_sfu_sum        (oc_sfu_sum),
    .oc_sfu_fifo_empty (oc_sfu_fifo_empty),
    .oc_sfu_fifo_rd    (oc_sfu_fifo_rd),
    .tc_sfu_fifo_rd    (tc_sfu_fifo_rd),
    .tc_sfu_sum        (tc_sfu_sum),
    .tc_sfu_fifo_empty (tc_sfu_fifo_empty)
  );

  `include "sfu_tb_tasks.svh"

  // peer model
  // pops its head on the DUT read strobe, outputs move 1 ns after the edge
  always @(posedge clk) begin
    if (rst_n && oc_sfu_fifo_rd && peer_q.size() == 0) begin
      $display("peer sum queue popped while empty at %0t ns", $time);
      abort_run();
    end else begin
      if (rst_n && oc_sfu_fifo_rd) begin
        void'(peer_q.pop_front());
      end
      #1;
      drive_peer();
    end
  end

  // hang guard
  always @(posedge clk) begin
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  initial begin
    void'($urandom(32'hbb3d_67e6));
    rst_n             = 1'b0;
    psum_in           = '0;
    sign_mode         = 1'b0;
    acc               = 1'b0;
    ofifo_valid       = 1'b0;
    div               = 1'b0;
    tc_sfu_fifo_rd    = 1'b0;
    oc_sfu_sum        = '0;
    oc_sfu_fifo_empty = 1'b1;

    // reset held for 5 cycles
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    after_reset_idle();
    unsigned_vector();
    signed_vector();
    queue_order();
    back_pressure();
    zero_sum();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* sfu.f */
+incdir+logic
+incdir+verification
logic/sfu_pkg.sv
logic/psum_abs_sum.sv
logic/sfu_fifo.sv
logic/norm_divider.sv
logic/sfu_top.sv
verification/sfu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the sfu testbench with Verilator and run it
# the verdict is taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sfu.f --top-module sfu_tb -o sfu_sim || exit 1
./obj_dir/sfu_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && echo "FAIL: sfu simulation" && exit 1
grep -q "ALL CHECKS PASSED" sim.log || { echo "FAIL: no verdict in sim.log"; exit 1; }
echo "PASS: sfu simulation"
